// File: cb_quantizer.f
+incdir+testbench
logic/jpeg_quant_pkg.sv
logic/quant_table_regs.sv
logic/quant_lane.sv
logic/quant_datapath.sv
logic/cb_quantizer.sv
testbench/cb_quantizer_tb.sv

// File: logic/cb_quantizer.sv
// Top level of the Cb block quantizer: the reciprocal table feeding the datapath.
// Blocks stream in with in_valid and leave PIPE_DEPTH cycles later with out_valid.
`timescale 1ns/1ps

module cb_quantizer import jpeg_quant_pkg::*; (
	input  logic      clk,
	input  logic      rst,

	// Coefficient block after the DCT, row-major
	input  logic      in_valid,
	input  coef_t     in_block [BLOCK_SIZE],

	// Reciprocal table write port
	input  logic      tbl_we,
	input  coef_idx_t tbl_addr,
	input  recip_t    tbl_wdata,

	// Quantized block
	output logic      out_valid,
	output coef_t     out_block [BLOCK_SIZE]
);

	recip_t recip_table [BLOCK_SIZE];

	quant_table_regs u_table (
		.clk         (clk),
		.rst         (rst),
		.tbl_we      (tbl_we),
		.tbl_addr    (tbl_addr),
		.tbl_wdata   (tbl_wdata),
		.recip_table (recip_table)
	);

	quant_datapath u_datapath (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_block    (in_block),
		.recip_table (recip_table),
		.out_valid   (out_valid),
		.out_block   (out_block)
	);

endmodule

// File: logic/jpeg_quant_pkg.sv
// Widths, scaling constants and coefficient types shared by the Cb quantizer.
// Every RTL module of the quantizer imports this package.
package jpeg_quant_pkg;

	// Input and output coefficients are two's complement
	localparam int COEF_W = 11;

	// A reciprocal is 4096 divided by the quantization step
	localparam int RECIP_W = 13;

	// Fraction bits carried by the reciprocal and removed after the multiply
	localparam int RECIP_SHIFT = 12;

	// The reciprocal never exceeds 2^RECIP_SHIFT so this width holds every product
	localparam int PROD_W = COEF_W + RECIP_SHIFT;

	// One 8x8 block in row-major order
	localparam int BLOCK_DIM = 8;
	localparam int BLOCK_SIZE = BLOCK_DIM * BLOCK_DIM;
	localparam int IDX_W = $clog2(BLOCK_SIZE);

	// Register stages between an accepted input and its output
	localparam int PIPE_DEPTH = 3;

	typedef logic signed [COEF_W-1:0] coef_t;

	typedef logic [RECIP_W-1:0] recip_t;

	typedef logic signed [PROD_W-1:0] prod_t;

	typedef logic [IDX_W-1:0] coef_idx_t;

	// Step 1, which is also the table default and the largest legal reciprocal
	localparam recip_t RECIP_ONE = recip_t'(1 << RECIP_SHIFT);

endpackage

// File: logic/quant_datapath.sv
// Valid delay chain and the 64 coefficient lanes that it steps through the pipeline.
// A block accepted at edge k leaves with out_valid after edge k + PIPE_DEPTH.
`timescale 1ns/1ps

module quant_datapath import jpeg_quant_pkg::*; (
	input  logic   clk,
	input  logic   rst,

	input  logic   in_valid,
	input  coef_t  in_block [BLOCK_SIZE],

	input  recip_t recip_table [BLOCK_SIZE],

	output logic   out_valid,
	output coef_t  out_block [BLOCK_SIZE]
);

	logic [PIPE_DEPTH:1] valid_sr;
	logic [PIPE_DEPTH:0] stage_en;
	logic [2:0]          warm_cnt;

	// Bit n of valid_sr marks a block whose stage n register loads at the next edge
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_sr <= '0;
			out_valid <= 1'b0;
		end else begin
			valid_sr <= {valid_sr[PIPE_DEPTH-1:1], in_valid};
			out_valid <= valid_sr[PIPE_DEPTH];
		end
	end

	// Stage 0 loads straight from the input valid
	assign stage_en = {valid_sr, in_valid};

	// Lane index is row * 8 + column, matching the row-major block layout
	for (genvar row = 0; row < BLOCK_DIM; row++) begin : g_row
		for (genvar col = 0; col < BLOCK_DIM; col++) begin : g_col
			quant_lane u_lane (
				.clk      (clk),
				.rst      (rst),
				.stage_en (stage_en),
				.coef     (in_block[row * BLOCK_DIM + col]),
				.recip    (recip_table[row * BLOCK_DIM + col]),
				.q        (out_block[row * BLOCK_DIM + col])
			);
		end
	end

	// Cycles since reset, saturating once the whole chain holds post-reset history
	always_ff @(posedge clk) begin
		if (rst) begin
			warm_cnt <= '0;
		end else if (warm_cnt != 3'(PIPE_DEPTH + 1)) begin
			warm_cnt <= warm_cnt + 3'd1;
		end
	end

	// out_valid is loaded at edge k + PIPE_DEPTH and first sampled one edge later
	fixed_latency: assert property (
		@(posedge clk) disable iff (rst)
		(warm_cnt == 3'(PIPE_DEPTH + 1)) |->
			(out_valid == $past(in_valid, PIPE_DEPTH + 1))
	)
	else begin
		$error("quant_datapath: out_valid does not follow in_valid by %0d cycles",
			PIPE_DEPTH);
	end

endmodule

// File: logic/quant_lane.sv
// Quantizer pipeline for one coefficient with sign extension, multiply, delay and rounding.
// Each register loads on its own stage enable so the lane moves with the valid chain.
`timescale 1ns/1ps

module quant_lane import jpeg_quant_pkg::*; (
	input  logic                clk,
	input  logic                rst,

	// Bit n enables the register of stage n, the last bit loads the output
	input  logic [PIPE_DEPTH:0] stage_en,

	input  coef_t               coef,
	input  recip_t              recip,
	output coef_t               q
);

	prod_t coef_ext;
	prod_t prod;
	prod_t prod_dly;
	coef_t rounded;

	// Stage 0 captures the coefficient already widened to the product width
	always_ff @(posedge clk) begin
		if (stage_en[0]) begin
			coef_ext <= prod_t'(coef);
		end
	end

	// Stage 1 multiplies by the reciprocal of this position.
	// The reciprocal gets a zero sign bit so the multiply stays signed
	always_ff @(posedge clk) begin
		if (stage_en[1]) begin
			prod <= coef_ext * prod_t'($signed({1'b0, recip}));
		end
	end

	// Stage 2 is a plain delay that leaves room to retime the multiplier
	always_ff @(posedge clk) begin
		if (stage_en[2]) begin
			prod_dly <= prod;
		end
	end

	// Drop the fraction bits and add the highest of them, so a half rounds up
	assign rounded = prod_dly[PROD_W-1:RECIP_SHIFT]
		+ {{(COEF_W-1){1'b0}}, prod_dly[RECIP_SHIFT-1]};

	// The output holds its value between blocks
	always_ff @(posedge clk) begin
		if (rst) begin
			q <= '0;
		end else if (stage_en[PIPE_DEPTH]) begin
			q <= rounded;
		end
	end

endmodule

// File: logic/quant_table_regs.sv
// Writable table of 64 quantization reciprocals, one per block position.
// The host loads precomputed 4096 / step values while no block is in flight.
`timescale 1ns/1ps

module quant_table_regs import jpeg_quant_pkg::*; (
	input  logic      clk,
	input  logic      rst,

	// Host write port
	input  logic      tbl_we,
	input  coef_idx_t tbl_addr,
	input  recip_t    tbl_wdata,

	// All reciprocals in row-major order, read by the multiply stage
	output recip_t    recip_table [BLOCK_SIZE]
);

	// An unprogrammed table is step 1 everywhere and passes coefficients unchanged
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < BLOCK_SIZE; i++) begin
				recip_table[i] <= RECIP_ONE;
			end
		end else if (tbl_we) begin
			recip_table[tbl_addr] <= tbl_wdata;
		end
	end

	// A zero reciprocal kills the position and anything above 4096 overflows the
	// 11-bit result in the rounding stage of every lane
	recip_legal: assert property (
		@(posedge clk) disable iff (rst)
		tbl_we |-> ((tbl_wdata != '0) && (tbl_wdata <= RECIP_ONE))
	)
	else begin
		$error("quant_table_regs: reciprocal %0d written at position %0d is out of range",
			tbl_wdata, tbl_addr);
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the Cb quantizer testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=cb_quantizer_tb

verilator --binary --timing --assert \
	-f cb_quantizer.f \
	--top-module "$TOP" \
	-Mdir "$BUILD_DIR"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG_FILE"; then
	echo "Simulation reported a failure, see $LOG_FILE"
	exit 1
fi

echo "Simulation finished without a reported failure"
exit 0

// File: testbench/cb_quantizer_tb_tasks.svh
// Directed tests and the value check for the Cb quantizer testbench.
// Included inside the testbench top module, so it shares its signals.
`ifndef CB_QUANTIZER_TB_TASKS_SVH
`define CB_QUANTIZER_TB_TASKS_SVH

task automatic check_value(input string name, input int actual, input int expected);
	check_count++;
	if (actual != expected) begin
		$display("FAILED at %0d ns: %s = %0d, expected %0d", $time, name, actual, expected);
		error_count++;
	end
endtask

task automatic report_test(input string name, input int errors_before);
	$display("Test %s finished with %0d errors", name, error_count - errors_before);
endtask

task automatic fill_random_block();
	for (int i = 0; i < BLOCK_SIZE; i++) begin
		stim_block[i] = rand_coef();
		exp_block[i] = quant_ref(stim_block[i], recip_model[i]);
	end
endtask

// Smallest reciprocal whose product with coef leaves the given low 12 bits
function automatic int find_recip(input int coef, input int low_bits);
	for (int r = 1; r <= int'(RECIP_ONE); r++) begin
		if ((((coef * r) % 4096) + 4096) % 4096 == low_bits) begin
			return r;
		end
	end
	return 0;
endfunction

// Junk on in_block with in_valid low must leave the reset outputs untouched
task automatic after_reset();
	int errors_before;
	errors_before = error_count;
	repeat (8) begin
		idle_cycles(1);
		check_value("out_valid", int'(out_valid), 0);
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			check_value($sformatf("out_block[%0d]", i), int'(out_block[i]), 0);
		end
	end
	report_test("after_reset", errors_before);
endtask

// Step 1 everywhere, so every coefficient must come out as it went in
task automatic identity_table();
	int errors_before;
	errors_before = error_count;
	for (int b = 0; b < 4; b++) begin
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			stim_block[i] = rand_coef();
		end
		stim_block[(b * 7) % BLOCK_SIZE] = coef_t'(-1024);
		stim_block[(b * 7 + 1) % BLOCK_SIZE] = coef_t'(-1);
		stim_block[BLOCK_SIZE - 1 - b] = coef_t'(1023);
		exp_block = stim_block;
		drive_block();
		if (b == 1) begin
			idle_cycles(1);
		end
	end
	wait_drain();
	report_test("identity_table", errors_before);
endtask

task automatic programmed_table();
	int          errors_before;
	logic [31:0] r;
	errors_before = error_count;
	for (int i = 0; i < BLOCK_SIZE; i++) begin
		r = lcg_next();
		write_table_entry(i, int'(r % 32'd4096) + 1);
	end
	end_table_write();
	for (int b = 0; b < 4; b++) begin
		fill_random_block();
		drive_block();
	end
	wait_drain();
	report_test("programmed_table", errors_before);
endtask

// Products whose low 12 bits sit just below, at and just above one half
task automatic rounding_boundaries();
	int errors_before;
	int lit_coef [6] = '{1, 1, 1, -1, -1, -1};
	int lit_recip [6] = '{2047, 2048, 2049, 2047, 2048, 2049};
	int lit_result [6] = '{0, 1, 1, 0, 0, -1};
	int coef;
	int mag;
	int recip;
	errors_before = error_count;
	for (int i = 0; i < BLOCK_SIZE; i++) begin
		if (i < 6) begin
			coef = lit_coef[i];
			recip = lit_recip[i];
		end else begin
			mag = int'(lcg_next() % 32'd511) * 2 + 1;
			coef = (((i / 3) % 2) == 1) ? -mag : mag;
			recip = find_recip(coef, 2047 + (i % 3));
			if (recip == 0) begin
				$display("No reciprocal found for coefficient %0d at position %0d", coef, i);
				error_count++;
				recip = int'(RECIP_ONE);
			end
		end
		stim_block[i] = coef_t'(coef);
		write_table_entry(i, recip);
	end
	end_table_write();
	for (int i = 0; i < BLOCK_SIZE; i++) begin
		if (i < 6) begin
			exp_block[i] = coef_t'(lit_result[i]);
		end else begin
			exp_block[i] = quant_ref(stim_block[i], recip_model[i]);
		end
	end
	drive_block();
	wait_drain();
	report_test("rounding_boundaries", errors_before);
endtask

// Three blocks back to back, then two separated by gaps of 2 and 3 cycles
task automatic stream_spacing();
	int errors_before;
	errors_before = error_count;
	for (int b = 0; b < 3; b++) begin
		fill_random_block();
		drive_block();
	end
	idle_cycles(2);
	fill_random_block();
	drive_block();
	idle_cycles(3);
	fill_random_block();
	drive_block();
	wait_drain();
	report_test("stream_spacing", errors_before);
endtask

`endif

// File: testbench/cb_quantizer_tb.sv
// Testbench for the Cb block quantizer with clock, reset, DUT, scoreboard and watchdog.
// The directed tests live in the included task file.
`timescale 1ns/1ps

module cb_quantizer_tb import jpeg_quant_pkg::*;;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 5;
	localparam int DRAIN_LIMIT = 16;

	// Rough length of each test in cycles, in the order they run
	localparam int TEST_CYCLES = 8
		+ (6 + DRAIN_LIMIT)
		+ (BLOCK_SIZE + 6 + DRAIN_LIMIT)
		+ (BLOCK_SIZE + 3 + DRAIN_LIMIT)
		+ (10 + DRAIN_LIMIT);
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 50;

	logic      clk;
	logic      rst;
	logic      in_valid;
	coef_t     in_block [BLOCK_SIZE];
	logic      tbl_we;
	coef_idx_t tbl_addr;
	recip_t    tbl_wdata;
	logic      out_valid;
	coef_t     out_block [BLOCK_SIZE];

	// Scoreboard of 64 expected coefficients per block and the cycle each block must appear
	coef_t exp_q [$];
	int    exp_cycle_q [$];

	coef_t stim_block [BLOCK_SIZE];
	coef_t exp_block [BLOCK_SIZE];
	coef_t last_out [BLOCK_SIZE];
	int    recip_model [BLOCK_SIZE];

	logic [31:0] lcg_state = 32'hedcd15a2;
	int          cycle_cnt = 0;
	logic        mon_en = 1'b0;
	int          check_count = 0;
	int          error_count = 0;

	cb_quantizer DUT (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_block  (in_block),
		.tbl_we    (tbl_we),
		.tbl_addr  (tbl_addr),
		.tbl_wdata (tbl_wdata),
		.out_valid (out_valid),
		.out_block (out_block)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		mon_en <= !rst;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the tests did not complete",
			WATCHDOG_CYCLES);
		$display("** FAIL **");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic coef_t rand_coef();
		logic [31:0] r;
		r = lcg_next();
		return coef_t'(r[26:16]);
	endfunction

	// floor((coef * recip + 2048) / 4096) kept to the coefficient width
	function automatic coef_t quant_ref(input coef_t coef, input int recip);
		longint prod;
		prod = longint'(coef) * longint'(recip) + longint'(1 << (RECIP_SHIFT - 1));
		return coef_t'(prod >>> RECIP_SHIFT);
	endfunction

	// Compare every completed block against the scoreboard, and idle outputs
	// against the last completed block
	task automatic check_outputs();
		int    exp_cyc;
		coef_t exp_c;
		if (out_valid) begin
			if (exp_cycle_q.size() == 0) begin
				$display("Unexpected block on out_block at %0d ns while none was in flight",
					$time);
				error_count++;
			end else begin
				exp_cyc = exp_cycle_q.pop_front();
				check_value("out_valid arrival cycle", cycle_cnt, exp_cyc);
				for (int i = 0; i < BLOCK_SIZE; i++) begin
					exp_c = exp_q.pop_front();
					check_value($sformatf("out_block[%0d]", i), int'(out_block[i]), int'(exp_c));
				end
			end
			last_out = out_block;
		end else begin
			for (int i = 0; i < BLOCK_SIZE; i++) begin
				check_value($sformatf("out_block[%0d] while idle", i),
					int'(out_block[i]), int'(last_out[i]));
			end
		end
	endtask

	initial begin
		forever begin
			@(negedge clk);
			if (mon_en) begin
				check_outputs();
			end
		end
	end

	// Present stim_block from the next falling edge and queue exp_block for 4 negedges later
	task automatic drive_block();
		@(negedge clk);
		in_valid = 1'b1;
		in_block = stim_block;
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			exp_q.push_back(exp_block[i]);
		end
		exp_cycle_q.push_back(cycle_cnt + PIPE_DEPTH + 1);
	endtask

	// Idle cycles carry junk on in_block that the DUT must ignore
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			in_valid = 1'b0;
			for (int i = 0; i < BLOCK_SIZE; i++) begin
				in_block[i] = rand_coef();
			end
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		@(negedge clk);
		in_valid = 1'b0;
		while (exp_cycle_q.size() != 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (exp_cycle_q.size() != 0) begin
			$display("%0d expected block(s) never came out of the DUT", exp_cycle_q.size());
			error_count++;
			exp_q.delete();
			exp_cycle_q.delete();
		end
	endtask

	task automatic write_table_entry(input int addr, input int value);
		@(negedge clk);
		tbl_we = 1'b1;
		tbl_addr = coef_idx_t'(addr);
		tbl_wdata = recip_t'(value);
		recip_model[addr] = value;
	endtask

	task automatic end_table_write();
		@(negedge clk);
		tbl_we = 1'b0;
	endtask

	`include "cb_quantizer_tb_tasks.svh"

	initial begin
		rst = 1'b1;
		in_valid = 1'b0;
		tbl_we = 1'b0;
		tbl_addr = '0;
		tbl_wdata = '0;
		for (int i = 0; i < BLOCK_SIZE; i++) begin
			in_block[i] = '0;
			last_out[i] = '0;
			recip_model[i] = int'(RECIP_ONE);
		end
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		after_reset();
		identity_table();
		programmed_table();
		rounding_boundaries();
		stream_spacing();

		$display("All tests done: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
